// File: filelist.f
hw/ucb_pkg.sv
hw/ucb_bus_in.sv
hw/ucb_decode.sv
hw/ucb_reg_unit.sv
hw/ucb_result.sv
hw/ucb_bus_out.sv
hw/ucb_top.sv
test/tb_ucb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_ucb \
		-Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/Vtb_ucb)"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: test/tb_ucb.sv
// Testbench for the unit control block
// Applies a table of bridge requests, models the registers and checks each outbound packet

module tb_ucb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [1:0] {op_rd, op_wr, op_bad} op_e;
   typedef logic [ucb_pkg::reg_width-1:0] data_t;
   typedef logic [ucb_pkg::addr_w-1:0]    addr_t;
   typedef logic [ucb_pkg::int_dev_w-1:0] field_t;
   typedef logic [ucb_pkg::pkt_bits-1:0]  pkt_t;

   // One table row, stall is the outbound stall level 0 to 3
   typedef struct packed {
      op_e                       op;
      logic [ucb_pkg::thr_w-1:0] thr;
      logic [ucb_pkg::buf_w-1:0] bid;
      addr_t                     addr;
      data_t                     data;
      logic [1:0]                stall;
   } entry_t;

   // Expected outbound packet
   typedef struct packed {
      ucb_pkg::ucb_pkt_e             typ;
      logic [ucb_pkg::thr_w-1:0]     thr;
      logic [ucb_pkg::buf_w-1:0]     bid;
      data_t                         data;
      logic [ucb_pkg::int_vec_w-1:0] vec;
      int                            entry;
   } exp_t;

   localparam int n_entries   = 18;
   localparam int cycle_limit = 80 * n_entries + 200;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic                          iob_ucb_vld;
   logic [ucb_pkg::in_width-1:0]  iob_ucb_data;
   logic                          iob_ucb_stall;
   logic                          ucb_iob_stall;
   logic                          ucb_iob_vld;
   logic [ucb_pkg::out_width-1:0] ucb_iob_data;

   entry_t     tbl [n_entries];
   data_t      ref_regs [ucb_pkg::reg_count];
   // Acks and nacks in request order, interrupts in their own order
   exp_t       ack_q [$];
   exp_t       int_q [$];
   int         ack_idx = 0;
   int         int_idx = 0;
   int         exp_total = 0;
   int         rx_count = 0;
   int         rx_beats = 0;
   int         cycles = 0;
   integer     seed = 32'hbf21;
   logic [1:0] stall_lvl = 2'd0;

   ucb_top ucb_top_inst (
      .clk(clk), .rst_n(rst_n),
      .iob_ucb_vld(iob_ucb_vld), .iob_ucb_data(iob_ucb_data), .iob_ucb_stall(iob_ucb_stall),
      .ucb_iob_stall(ucb_iob_stall), .ucb_iob_vld(ucb_iob_vld), .ucb_iob_data(ucb_iob_data)
   );

   always #50 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         stop_run($sformatf("Timeout after %0d cycles, %0d of %0d packets received",
            cycles, rx_count, exp_total));
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_type(input string name, input ucb_pkg::ucb_pkt_e want,
                             input ucb_pkg::ucb_pkt_e got);
      if (got !== want) begin
         stop_run($sformatf("** Error %s type: expected %h, actual %h", name, want, got));
      end
   endtask

   task automatic check_data(input string name, input data_t want, input data_t got);
      if (got !== want) begin
         stop_run($sformatf("** Error %s: expected %h, actual %h", name, want, got));
      end
   endtask

   task automatic check_field(input string name, input field_t want, input field_t got);
      if (got !== want) begin
         stop_run($sformatf("** Error %s: expected %h, actual %h", name, want, got));
      end
   endtask

   task automatic check_level(input string name, input logic want, input logic got);
      if (got !== want) begin
         stop_run($sformatf("** Error %s: expected %b, actual %b", name, want, got));
      end
   endtask

   // Inputs change 5 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   // Beat goes in on the next edge unless the unit stalls this cycle
   task automatic send_packet(input pkt_t pkt, input int n);
      int i;
      i = 0;
      while (i < ucb_pkg::in_beats) begin
         iob_ucb_vld  = 1'b1;
         iob_ucb_data = pkt[i*ucb_pkg::in_width +: ucb_pkg::in_width];
         if (!ucb_iob_stall) begin
            i++;
         end
         next_cycle();
      end
      // Last beat fills the buffer, which stalls the bridge
      check_level($sformatf("entry %0d full stall", n), 1'b1, ucb_iob_stall);
   endtask

   function automatic data_t request_header(input entry_t e);
      data_t hdr;
      hdr = '0;
      hdr[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w] =
         (e.op == op_rd) ? ucb_pkg::read_req : ucb_pkg::write_req;
      hdr[ucb_pkg::thr_lo +: ucb_pkg::thr_w] = e.thr;
      hdr[ucb_pkg::buf_lo +: ucb_pkg::buf_w] = e.bid;
      // Any size but double word makes a bad write
      hdr[ucb_pkg::size_lo +: ucb_pkg::size_w] = (e.op == op_bad) ? 3'b010 : ucb_pkg::size_dword;
      hdr[ucb_pkg::addr_lo +: ucb_pkg::addr_w] = e.addr;
      return hdr;
   endfunction

   // Reserved bits stay zero
   function automatic data_t response_header(input exp_t x);
      data_t hdr;
      hdr = '0;
      hdr[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w] = x.typ;
      hdr[ucb_pkg::thr_lo +: ucb_pkg::thr_w] = x.thr;
      if (x.typ == ucb_pkg::int_pkt) begin
         hdr[ucb_pkg::int_dev_lo +: ucb_pkg::int_dev_w]   = ucb_pkg::ucb_dev_id;
         hdr[ucb_pkg::int_stat_lo +: ucb_pkg::int_stat_w] = 4'b0001;
         hdr[ucb_pkg::int_vec_lo +: ucb_pkg::int_vec_w]   = x.vec;
      end else begin
         hdr[ucb_pkg::buf_lo +: ucb_pkg::buf_w] = x.bid;
      end
      return hdr;
   endfunction

   function automatic exp_t make_exp(input ucb_pkg::ucb_pkt_e typ, input entry_t e,
                                     input data_t data, input int n);
      exp_t x;
      x.typ   = typ;
      x.thr   = e.thr;
      x.bid   = e.bid;
      x.data  = data;
      x.vec   = e.data[ucb_pkg::int_vec_w-1:0];
      x.entry = n;
      return x;
   endfunction

   //////////////////////////////
   // Reference model
   //////////////////////////////

   task automatic apply_model(input entry_t e, input int n);
      logic in_range;
      in_range = e.addr < addr_t'(ucb_pkg::reg_count);
      case (e.op)
         op_wr: begin
            // Out of range writes are dropped
            if (in_range) begin
               ref_regs[e.addr[ucb_pkg::reg_idx_w-1:0]] = e.data;
               if (e.addr == addr_t'(ucb_pkg::doorbell_addr)) begin
                  int_q.push_back(make_exp(ucb_pkg::int_pkt, e, '0, n));
                  exp_total++;
               end
            end
         end
         op_rd: begin
            if (in_range) begin
               ack_q.push_back(make_exp(ucb_pkg::read_ack, e,
                  ref_regs[e.addr[ucb_pkg::reg_idx_w-1:0]], n));
            end else begin
               ack_q.push_back(make_exp(ucb_pkg::read_nack, e, '0, n));
            end
            exp_total++;
         end
         // Bad-size write changes nothing
         default: begin
         end
      endcase
   endtask

   // Match a finished packet against the next expected one of its kind
   task automatic handle_packet(input pkt_t rx);
      exp_t              want;
      ucb_pkg::ucb_pkt_e typ;
      string             name;
      typ = ucb_pkg::ucb_pkt_e'(rx[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w]);
      if (typ == ucb_pkg::int_pkt) begin
         if (int_idx >= int_q.size()) begin
            stop_run("Interrupt packet arrived with no interrupt expected");
         end else begin
            want = int_q[int_idx];
            int_idx++;
         end
      end else begin
         if (ack_idx >= ack_q.size()) begin
            stop_run("Response packet arrived with no read outstanding");
         end else begin
            want = ack_q[ack_idx];
            ack_idx++;
         end
      end
      name = $sformatf("entry %0d", want.entry);
      check_type(name, want.typ, typ);
      check_field($sformatf("%s thread", name), field_t'(want.thr),
         field_t'(rx[ucb_pkg::thr_lo +: ucb_pkg::thr_w]));
      if (typ == ucb_pkg::int_pkt) begin
         check_field($sformatf("%s vector", name), field_t'(want.vec),
            field_t'(rx[ucb_pkg::int_vec_lo +: ucb_pkg::int_vec_w]));
         check_field($sformatf("%s status", name), field_t'(4'b0001),
            field_t'(rx[ucb_pkg::int_stat_lo +: ucb_pkg::int_stat_w]));
         check_field($sformatf("%s device", name), ucb_pkg::ucb_dev_id,
            rx[ucb_pkg::int_dev_lo +: ucb_pkg::int_dev_w]);
      end else begin
         check_field($sformatf("%s buffer", name), field_t'(want.bid),
            field_t'(rx[ucb_pkg::buf_lo +: ucb_pkg::buf_w]));
         if (typ == ucb_pkg::read_ack) begin
            check_data($sformatf("%s data", name), want.data,
               rx[ucb_pkg::data_lo +: ucb_pkg::reg_width]);
         end
      end
      check_data($sformatf("%s header", name), response_header(want),
         rx[ucb_pkg::data_lo-1:0]);
   endtask

   //////////////////////////////
   // Stimulus table
   //////////////////////////////

   task automatic load_table();
      // Write then read back, nack, bad size, doorbell
      tbl[0]  = '{op_wr,  5'd3,  2'd1, 40'd2,     64'h0123_4567_89ab_cdef, 2'd0};
      tbl[1]  = '{op_rd,  5'd3,  2'd1, 40'd2,     64'h0,                   2'd0};
      tbl[2]  = '{op_rd,  5'd4,  2'd2, 40'd8,     64'h0,                   2'd0};
      tbl[3]  = '{op_bad, 5'd5,  2'd0, 40'd2,     64'hdead_beef_dead_beef, 2'd0};
      tbl[4]  = '{op_rd,  5'd5,  2'd0, 40'd2,     64'h0,                   2'd1};
      tbl[5]  = '{op_wr,  5'd9,  2'd3, 40'd7,     64'h0000_0000_0000_00fd, 2'd1};
      tbl[6]  = '{op_rd,  5'd9,  2'd3, 40'd7,     64'h0,                   2'd1};
      // Back to back traffic under heavier stall
      tbl[7]  = '{op_wr,  5'd1,  2'd0, 40'd0,     64'hfeed_face_cafe_f00d, 2'd2};
      tbl[8]  = '{op_wr,  5'd2,  2'd1, 40'd5,     64'h5555_aaaa_3333_cccc, 2'd2};
      tbl[9]  = '{op_rd,  5'd10, 2'd2, 40'd0,     64'h0,                   2'd2};
      tbl[10] = '{op_rd,  5'd11, 2'd3, 40'd5,     64'h0,                   2'd3};
      tbl[11] = '{op_rd,  5'd12, 2'd0, 40'h100,   64'h0,                   2'd2};
      tbl[12] = '{op_rd,  5'd13, 2'd1, 40'd2,     64'h0,                   2'd3};
      tbl[13] = '{op_wr,  5'd17, 2'd2, 40'd7,     64'h1234_0000_0000_0042, 2'd2};
      tbl[14] = '{op_rd,  5'd18, 2'd3, 40'd7,     64'h0,                   2'd3};
      // Out of range write must not alias onto register 4
      tbl[15] = '{op_wr,  5'd20, 2'd0, 40'd12,    64'hbad0_bad0_bad0_bad0, 2'd1};
      tbl[16] = '{op_rd,  5'd21, 2'd1, 40'd4,     64'h0,                   2'd2};
      tbl[17] = '{op_rd,  5'd31, 2'd2, 40'd12,    64'h0,                   2'd3};
   endtask

   //////////////////////////////
   // Bridge driver
   //////////////////////////////

   initial begin
      rst_n        = 1'b0;
      iob_ucb_vld  = 1'b0;
      iob_ucb_data = '0;
      for (int i = 0; i < ucb_pkg::reg_count; i++) begin
         ref_regs[i] = '0;
      end
      load_table();
      repeat (8) @(posedge clk);
      #5;
      rst_n = 1'b1;
      // Both bridge directions idle out of reset
      check_level("reset stall", 1'b0, ucb_iob_stall);
      check_level("reset valid", 1'b0, ucb_iob_vld);
      for (int n = 0; n < n_entries; n++) begin
         stall_lvl <= tbl[n].stall;
         apply_model(tbl[n], n);
         send_packet({tbl[n].data, request_header(tbl[n])}, n);
      end
      iob_ucb_vld = 1'b0;
      // Drain, then watch for anything extra
      while (rx_count < exp_total) begin
         next_cycle();
      end
      repeat (40) next_cycle();
      if (rx_count == exp_total && rx_beats == 0 &&
          ack_idx == ack_q.size() && int_idx == int_q.size()) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         stop_run($sformatf("Packet count wrong, %0d received with %0d expected",
            rx_count, exp_total));
      end
   end

   //////////////////////////////
   // Outbound stall and collector
   //////////////////////////////

   initial begin
      pkt_t        rx;
      int          len;
      logic [31:0] rnd;
      logic        stall;
      rx            = '0;
      len           = 0;
      iob_ucb_stall = 1'b0;
      @(posedge rst_n);
      forever begin
         next_cycle();
         rnd   = $random(seed);
         stall = rnd[1:0] < stall_lvl;
         iob_ucb_stall = stall;
         // Beat is taken at the next edge
         if (ucb_iob_vld && !stall) begin
            if (rx_beats == 0) begin
               len = (ucb_iob_data[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w] == ucb_pkg::read_ack) ?
                  ucb_pkg::out_beats_long : ucb_pkg::out_beats_short;
            end
            rx[rx_beats*ucb_pkg::out_width +: ucb_pkg::out_width] = ucb_iob_data;
            rx_beats++;
            if (rx_beats == len) begin
               rx_count++;
               handle_packet(rx);
               rx       = '0;
               rx_beats = 0;
            end
         end
      end
   end

endmodule

// File: hw/ucb_top.sv
// Unit control block top level
// Bridge in, decode, register unit, result buffers, bridge out

module ucb_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          iob_ucb_vld,
   input  logic [ucb_pkg::in_width-1:0]  iob_ucb_data,
   input  logic                          iob_ucb_stall,
   output logic                          ucb_iob_stall,
   output logic                          ucb_iob_vld,
   output logic [ucb_pkg::out_width-1:0] ucb_iob_data
);

   // Inbound buffer
   logic                           indata_vld;
   logic [ucb_pkg::pkt_bits-1:0]   indata;
   logic                           hold;
   // Requests to the register unit
   logic                           rd_req_vld;
   logic                           wr_req_vld;
   logic [ucb_pkg::thr_w-1:0]      thr_id_in;
   logic [ucb_pkg::buf_w-1:0]      buf_id_in;
   logic [ucb_pkg::addr_w-1:0]     addr_in;
   logic [ucb_pkg::reg_width-1:0]  data_in;
   // Responses and interrupts
   logic                           rd_ack_vld;
   logic                           rd_nack_vld;
   logic [ucb_pkg::thr_w-1:0]      thr_id_out;
   logic [ucb_pkg::buf_w-1:0]      buf_id_out;
   logic [ucb_pkg::reg_width-1:0]  data_out;
   logic                           int_vld;
   logic [ucb_pkg::thr_w-1:0]      int_thr_id;
   logic [ucb_pkg::int_stat_w-1:0] int_stat;
   logic [ucb_pkg::int_vec_w-1:0]  int_vec;
   logic                           int_busy;
   logic                           ack_rd;
   // Outbound packet
   logic                           out_wr;
   logic [ucb_pkg::pkt_bits-1:0]   out_buf;
   logic                           out_short;
   logic                           out_busy;

   //////////////////////////////
   // Inbound path
   //////////////////////////////

   ucb_bus_in ucb_bus_in_inst (
      .clk(clk), .rst_n(rst_n),
      .iob_ucb_vld(iob_ucb_vld), .iob_ucb_data(iob_ucb_data), .hold(hold),
      .ucb_iob_stall(ucb_iob_stall), .indata_vld(indata_vld), .indata(indata)
   );

   ucb_decode ucb_decode_inst (
      .clk(clk), .rst_n(rst_n),
      .indata_vld(indata_vld), .indata(indata), .ack_rd(ack_rd), .hold(hold),
      .rd_req_vld(rd_req_vld), .wr_req_vld(wr_req_vld),
      .thr_id_in(thr_id_in), .buf_id_in(buf_id_in),
      .addr_in(addr_in), .data_in(data_in)
   );

   //////////////////////////////
   // Execute
   //////////////////////////////

   ucb_reg_unit ucb_reg_unit_inst (
      .clk(clk), .rst_n(rst_n),
      .rd_req_vld(rd_req_vld), .wr_req_vld(wr_req_vld),
      .thr_id_in(thr_id_in), .buf_id_in(buf_id_in),
      .addr_in(addr_in), .data_in(data_in), .int_busy(int_busy),
      .rd_ack_vld(rd_ack_vld), .rd_nack_vld(rd_nack_vld),
      .thr_id_out(thr_id_out), .buf_id_out(buf_id_out), .data_out(data_out),
      .int_vld(int_vld), .int_thr_id(int_thr_id),
      .int_stat(int_stat), .int_vec(int_vec)
   );

   //////////////////////////////
   // Outbound path
   //////////////////////////////

   ucb_result ucb_result_inst (
      .clk(clk), .rst_n(rst_n),
      .rd_ack_vld(rd_ack_vld), .rd_nack_vld(rd_nack_vld),
      .thr_id_out(thr_id_out), .buf_id_out(buf_id_out), .data_out(data_out),
      .int_vld(int_vld), .int_thr_id(int_thr_id),
      .int_stat(int_stat), .int_vec(int_vec), .out_busy(out_busy),
      .int_busy(int_busy), .ack_rd(ack_rd),
      .out_wr(out_wr), .out_buf(out_buf), .out_short(out_short)
   );

   ucb_bus_out ucb_bus_out_inst (
      .clk(clk), .rst_n(rst_n),
      .out_wr(out_wr), .out_buf(out_buf), .out_short(out_short),
      .iob_ucb_stall(iob_ucb_stall), .out_busy(out_busy),
      .ucb_iob_vld(ucb_iob_vld), .ucb_iob_data(ucb_iob_data)
   );

endmodule

// File: hw/ucb_bus_out.sv
// Outbound serializer onto the 8-bit bridge bus
// Sends 8 or 16 beats per packet and freezes while the bridge stalls

module ucb_bus_out (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          out_wr,
   input  logic [ucb_pkg::pkt_bits-1:0]  out_buf,
   input  logic                          out_short,
   input  logic                          iob_ucb_stall,
   output logic                          out_busy,
   output logic                          ucb_iob_vld,
   output logic [ucb_pkg::out_width-1:0] ucb_iob_data
);

   logic [ucb_pkg::pkt_bits-1:0]  shreg;
   logic [ucb_pkg::out_cnt_w-1:0] beats_left;
   logic                          advance;

   // Beat leaves when bridge is not stalling
   assign advance = ucb_iob_vld && !iob_ucb_stall;

   //////////////////////////////
   // Beat counter
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beats_left <= '0;
      end else if (out_wr) begin
         beats_left <= out_short ? ucb_pkg::out_cnt_short : ucb_pkg::out_cnt_long;
      end else if (advance) begin
         beats_left <= beats_left - 1'b1;
      end
   end

   // Low byte always on the bus
   always_ff @(posedge clk) begin
      if (out_wr) begin
         shreg <= out_buf;
      end else if (advance) begin
         shreg <= shreg >> ucb_pkg::out_width;
      end
   end

   // Valid stays up through a stall
   assign ucb_iob_vld  = beats_left != '0;
   assign out_busy     = ucb_iob_vld;
   assign ucb_iob_data = shreg[ucb_pkg::out_width-1:0];

   // Result arbitration must wait for the current packet
   a_no_overrun : assert property (@(posedge clk) disable iff (!rst_n)
      out_wr |-> !out_busy);

endmodule

// File: hw/ucb_result.sv
// Outbound ack and interrupt buffering
// One entry each, round-robin into the outbound serializer

module ucb_result (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           rd_ack_vld,
   input  logic                           rd_nack_vld,
   input  logic [ucb_pkg::thr_w-1:0]      thr_id_out,
   input  logic [ucb_pkg::buf_w-1:0]      buf_id_out,
   input  logic [ucb_pkg::reg_width-1:0]  data_out,
   input  logic                           int_vld,
   input  logic [ucb_pkg::thr_w-1:0]      int_thr_id,
   input  logic [ucb_pkg::int_stat_w-1:0] int_stat,
   input  logic [ucb_pkg::int_vec_w-1:0]  int_vec,
   input  logic                           out_busy,
   output logic                           int_busy,
   output logic                           ack_rd,
   output logic                           out_wr,
   output logic [ucb_pkg::pkt_bits-1:0]   out_buf,
   output logic                           out_short
);

   logic                           ack_wr;
   logic                           ack_full;
   logic                           ack_nack;
   logic [ucb_pkg::thr_w-1:0]      ack_thr;
   logic [ucb_pkg::buf_w-1:0]      ack_buf_id;
   logic [ucb_pkg::reg_width-1:0]  ack_data;
   logic                           int_full;
   logic                           int_rd;
   logic [ucb_pkg::thr_w-1:0]      int_thr_q;
   logic [ucb_pkg::int_stat_w-1:0] int_stat_q;
   logic [ucb_pkg::int_vec_w-1:0]  int_vec_q;
   logic                           int_last;
   ucb_pkg::ucb_pkt_e              ack_type;

   //////////////////////////////
   // Buffer valid flags
   //////////////////////////////

   assign ack_wr = rd_ack_vld || rd_nack_vld;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_full <= 1'b0;
         int_full <= 1'b0;
         int_last <= 1'b0;
      end else begin
         if (ack_wr) begin
            ack_full <= 1'b1;
         end else if (ack_rd) begin
            ack_full <= 1'b0;
         end
         if (int_vld) begin
            int_full <= 1'b1;
         end else if (int_rd) begin
            int_full <= 1'b0;
         end
         // Remember who won the last grant
         if (out_wr) begin
            int_last <= int_rd;
         end
      end
   end

   // Payloads load with their valid pulse
   always_ff @(posedge clk) begin
      if (ack_wr) begin
         ack_nack   <= rd_nack_vld;
         ack_thr    <= thr_id_out;
         ack_buf_id <= buf_id_out;
         ack_data   <= data_out;
      end
      if (int_vld) begin
         int_thr_q  <= int_thr_id;
         int_stat_q <= int_stat;
         int_vec_q  <= int_vec;
      end
   end

   assign int_busy = int_full;

   //////////////////////////////
   // Round-robin arbitration
   //////////////////////////////

   // With both full, the one not served last goes first
   assign ack_rd = !out_busy && ack_full && (!int_full || int_last);
   assign int_rd = !out_busy && int_full && (!ack_full || !int_last);
   assign out_wr = ack_rd || int_rd;

   // Nack and interrupt are header only
   assign out_short = ack_rd ? ack_nack : 1'b1;
   assign ack_type  = ack_nack ? ucb_pkg::read_nack : ucb_pkg::read_ack;

   // Outbound packet, reserved fields zero
   always_comb begin
      out_buf = '0;
      if (ack_rd) begin
         out_buf[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w] = ack_type;
         out_buf[ucb_pkg::thr_lo +: ucb_pkg::thr_w] = ack_thr;
         out_buf[ucb_pkg::buf_lo +: ucb_pkg::buf_w] = ack_buf_id;
         if (!ack_nack) begin
            out_buf[ucb_pkg::data_lo +: ucb_pkg::reg_width] = ack_data;
         end
      end else begin
         out_buf[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w] = ucb_pkg::int_pkt;
         out_buf[ucb_pkg::thr_lo +: ucb_pkg::thr_w] = int_thr_q;
         out_buf[ucb_pkg::int_dev_lo +: ucb_pkg::int_dev_w]   = ucb_pkg::ucb_dev_id;
         out_buf[ucb_pkg::int_stat_lo +: ucb_pkg::int_stat_w] = int_stat_q;
         out_buf[ucb_pkg::int_vec_lo +: ucb_pkg::int_vec_w]   = int_vec_q;
      end
   end

endmodule

// File: hw/ucb_reg_unit.sv
// Local register unit behind the control block
// Executes reads and writes, returns ack or nack, raises doorbell interrupts

module ucb_reg_unit (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           rd_req_vld,
   input  logic                           wr_req_vld,
   input  logic [ucb_pkg::thr_w-1:0]      thr_id_in,
   input  logic [ucb_pkg::buf_w-1:0]      buf_id_in,
   input  logic [ucb_pkg::addr_w-1:0]     addr_in,
   input  logic [ucb_pkg::reg_width-1:0]  data_in,
   input  logic                           int_busy,
   output logic                           rd_ack_vld,
   output logic                           rd_nack_vld,
   output logic [ucb_pkg::thr_w-1:0]      thr_id_out,
   output logic [ucb_pkg::buf_w-1:0]      buf_id_out,
   output logic [ucb_pkg::reg_width-1:0]  data_out,
   output logic                           int_vld,
   output logic [ucb_pkg::thr_w-1:0]      int_thr_id,
   output logic [ucb_pkg::int_stat_w-1:0] int_stat,
   output logic [ucb_pkg::int_vec_w-1:0]  int_vec
);

   logic [ucb_pkg::reg_width-1:0] regs [ucb_pkg::reg_count];
   logic [ucb_pkg::reg_idx_w-1:0] idx;
   logic                          in_range;
   logic                          doorbell_wr;
   logic                          int_pend;

   // In range when nothing is set above the index bits
   assign idx      = addr_in[ucb_pkg::reg_idx_w-1:0];
   assign in_range = addr_in[ucb_pkg::addr_w-1:ucb_pkg::reg_idx_w] == '0;

   //////////////////////////////
   // Register file
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < ucb_pkg::reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_req_vld && in_range) begin
         regs[idx] <= data_in;
      end
   end

   // Response one cycle after the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ack_vld  <= 1'b0;
         rd_nack_vld <= 1'b0;
      end else begin
         rd_ack_vld  <= rd_req_vld && in_range;
         rd_nack_vld <= rd_req_vld && !in_range;
      end
   end

   // Nack data is don't care, result drops it
   always_ff @(posedge clk) begin
      if (rd_req_vld) begin
         thr_id_out <= thr_id_in;
         buf_id_out <= buf_id_in;
         data_out   <= regs[idx];
      end
   end

   //////////////////////////////
   // Doorbell interrupt
   //////////////////////////////

   assign doorbell_wr = wr_req_vld && in_range && idx == ucb_pkg::doorbell_addr;
   // Fires as soon as the interrupt buffer is free
   assign int_vld     = int_pend && !int_busy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         int_pend <= 1'b0;
      end else if (doorbell_wr) begin
         int_pend <= 1'b1;
      end else if (int_vld) begin
         int_pend <= 1'b0;
      end
   end

   // Thread and vector come from the doorbell write
   always_ff @(posedge clk) begin
      if (doorbell_wr) begin
         int_thr_id <= thr_id_in;
         int_vec    <= data_in[ucb_pkg::int_vec_w-1:0];
      end
   end

   assign int_stat = ucb_pkg::int_stat_door;

   // Result must take the interrupt on the cycle it fires
   a_int_taken : assert property (@(posedge clk) disable iff (!rst_n)
      int_vld |=> int_busy);

endmodule

// File: hw/ucb_decode.sv
// Inbound packet decode and read tracking
// Turns the buffered packet into read and write pulses, one read in flight

module ucb_decode (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          indata_vld,
   input  logic [ucb_pkg::pkt_bits-1:0]  indata,
   input  logic                          ack_rd,
   output logic                          hold,
   output logic                          rd_req_vld,
   output logic                          wr_req_vld,
   output logic [ucb_pkg::thr_w-1:0]     thr_id_in,
   output logic [ucb_pkg::buf_w-1:0]     buf_id_in,
   output logic [ucb_pkg::addr_w-1:0]    addr_in,
   output logic [ucb_pkg::reg_width-1:0] data_in
);

   ucb_pkg::ucb_pkt_e pkt_type;
   logic              read_pending;
   logic              write_pending;
   logic              size_ok;
   logic              read_outstanding;

   //////////////////////////////
   // Type and size decode
   //////////////////////////////

   assign pkt_type = ucb_pkg::ucb_pkt_e'(indata[ucb_pkg::pkt_lo +: ucb_pkg::pkt_w]);

   assign read_pending  = indata_vld && pkt_type == ucb_pkg::read_req;
   assign write_pending = indata_vld && pkt_type == ucb_pkg::write_req;
   // Anything but a double word write is silently dropped
   assign size_ok = indata[ucb_pkg::size_lo +: ucb_pkg::size_w] == ucb_pkg::size_dword;

   //////////////////////////////
   // Outstanding read
   //////////////////////////////

   // Set when a read goes out, cleared when its ack leaves
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         read_outstanding <= 1'b0;
      end else if (rd_req_vld) begin
         read_outstanding <= 1'b1;
      end else if (ack_rd) begin
         read_outstanding <= 1'b0;
      end
   end

   // Second read parks in the inbound buffer
   assign hold       = read_pending && read_outstanding;
   assign rd_req_vld = read_pending && !read_outstanding;
   assign wr_req_vld = write_pending && size_ok;

   // Request fields straight from the buffer
   assign thr_id_in = indata[ucb_pkg::thr_lo +: ucb_pkg::thr_w];
   assign buf_id_in = indata[ucb_pkg::buf_lo +: ucb_pkg::buf_w];
   assign addr_in   = indata[ucb_pkg::addr_lo +: ucb_pkg::addr_w];
   assign data_in   = indata[ucb_pkg::data_lo +: ucb_pkg::reg_width];

   // Ack only drains while a read is outstanding, so no overlap with a new read
   a_rd_ack_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(rd_req_vld && ack_rd));

endmodule

// File: hw/ucb_bus_in.sv
// Inbound deserializer for the bridge request bus
// Collects four 32-bit beats into one 128-bit packet buffer

module ucb_bus_in (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         iob_ucb_vld,
   input  logic [ucb_pkg::in_width-1:0] iob_ucb_data,
   input  logic                         hold,
   output logic                         ucb_iob_stall,
   output logic                         indata_vld,
   output logic [ucb_pkg::pkt_bits-1:0] indata
);

   logic [ucb_pkg::in_cnt_w-1:0] beat_cnt;
   logic                         buf_full;
   logic                         accept;

   // Bridge beat taken only while buffer is empty
   assign accept = iob_ucb_vld && !buf_full;

   //////////////////////////////
   // Beat count and full flag
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_cnt <= '0;
         buf_full <= 1'b0;
      end else begin
         // Counter wraps back to zero after the last beat
         if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
         if (accept && beat_cnt == ucb_pkg::in_last) begin
            buf_full <= 1'b1;
         end else if (buf_full && !hold) begin
            // Decode consumed the packet
            buf_full <= 1'b0;
         end
      end
   end

   // Least significant beat first, shift toward the bottom
   always_ff @(posedge clk) begin
      if (accept) begin
         indata <= {iob_ucb_data, indata[ucb_pkg::pkt_bits-1:ucb_pkg::in_width]};
      end
   end

   // Full buffer both presents the packet and holds off the bridge
   assign indata_vld    = buf_full;
   assign ucb_iob_stall = buf_full;

endmodule

// File: hw/ucb_pkg.sv
// Shared definitions for the unit control block and its testbench
// Packet types, header field positions, bus widths and the register map

package ucb_pkg;

   //////////////////////////////
   // Packet types
   //////////////////////////////

   // Low nibble of every header
   typedef enum logic [3:0] {
      read_req  = 4'b0100,
      write_req = 4'b0101,
      read_ack  = 4'b0001,
      read_nack = 4'b0011,
      int_pkt   = 4'b1000
   } ucb_pkt_e;

   //////////////////////////////
   // Bus and data widths
   //////////////////////////////

   // Bridge to unit and unit to bridge
   localparam int in_width  = 32;
   localparam int out_width = 8;
   // Register and payload width
   localparam int reg_width = 64;
   // Header plus data
   localparam int pkt_bits  = 128;

   //////////////////////////////
   // Header fields
   //////////////////////////////

   localparam int pkt_w  = 4;
   localparam int thr_w  = 5;
   localparam int buf_w  = 2;
   localparam int size_w = 3;
   localparam int addr_w = 40;

   // Request and ack layout
   localparam int pkt_lo  = 0;
   localparam int thr_lo  = 4;
   localparam int buf_lo  = 9;
   localparam int size_lo = 12;
   localparam int addr_lo = 15;
   localparam int data_lo = 64;

   // Only double word writes are executed
   localparam logic [size_w-1:0] size_dword = 3'b011;

   // Interrupt layout, above the thread field
   localparam int int_dev_w   = 9;
   localparam int int_stat_w  = 4;
   localparam int int_vec_w   = 6;
   localparam int int_dev_lo  = 10;
   localparam int int_stat_lo = 19;
   localparam int int_vec_lo  = 23;

   //////////////////////////////
   // Beat counts
   //////////////////////////////

   localparam int in_beats        = 4;
   localparam int out_beats_long  = 16;
   localparam int out_beats_short = 8;

   localparam int in_cnt_w = $clog2(in_beats);
   localparam logic [in_cnt_w-1:0] in_last = in_cnt_w'(in_beats - 1);

   // Outbound counter also has to hold 16
   localparam int out_cnt_w = $clog2(out_beats_long + 1);
   localparam logic [out_cnt_w-1:0] out_cnt_long  = out_cnt_w'(out_beats_long);
   localparam logic [out_cnt_w-1:0] out_cnt_short = out_cnt_w'(out_beats_short);

   //////////////////////////////
   // Register map
   //////////////////////////////

   localparam int reg_count = 8;
   localparam int reg_idx_w = $clog2(reg_count);
   // Doorbell register index
   localparam logic [reg_idx_w-1:0] doorbell_addr = reg_idx_w'(7);
   // Interrupt identity of this unit
   localparam logic [int_dev_w-1:0]  ucb_dev_id    = 9'h1a;
   localparam logic [int_stat_w-1:0] int_stat_door = 4'b0001;

endpackage
